//--- logic/weight_load_ctrl.sv
`timescale 1ns/1ps

module weight_load_ctrl (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load_start,    // one-cycle pulse
  input  wl_pkg::mem_adr_t     load_base,     // first word address
  input  wl_pkg::word_cnt_t    load_count,    // words to fetch
  input  logic                 mem_rd_valid,  // returns come in request order
  input  wl_pkg::weight_word_t mem_rd_data,
  output logic                 mem_rd_req,
  output wl_pkg::mem_adr_t     mem_rd_adr,
  output wl_pkg::buf_wr_s      buf_wr,        // into the fill bank
  output logic                 load_done      // pulse after last write
);
  import wl_pkg::*;

  load_state_e         state;
  logic [CREDIT_W-1:0] credits;   // reads we may still launch
  mem_adr_t            req_adr;   // next address to request
  word_cnt_t           req_left;  // requests not yet issued
  buf_adr_t            wr_adr;    // bank slot for next return
  logic                accept;    // load_start taken
  logic                last_ret;  // final outstanding word arrives

  ////////////////////////////////////////////////////////////////////////////
  // request side
  ////////////////////////////////////////////////////////////////////////////

  assign accept     = (state == idle) && load_start;  // busy starts dropped
  assign mem_rd_req = (state == fetch) && (credits != '0);
  assign mem_rd_adr = req_adr;

  // only one read outstanding and it comes back now
  assign last_ret = (state == drain) && mem_rd_valid &&
                    (credits == CREDIT_W'(RD_CREDITS - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= CREDIT_W'(RD_CREDITS);  // full pool
    end else begin
      case ({mem_rd_req, mem_rd_valid})
        2'b10:   credits <= credits - 1'b1;  // spend
        2'b01:   credits <= credits + 1'b1;  // give back
        default: credits <= credits;         // idle or both at once
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req_adr  <= '0;
      req_left <= '0;
    end else if (accept) begin
      req_adr  <= load_base;
      req_left <= load_count;
    end else if (mem_rd_req) begin
      req_adr  <= req_adr + 1'b1;   // sequential words
      req_left <= req_left - 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and return side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      load_done <= 1'b0;
    end else begin
      load_done <= last_ret;  // one cycle behind last write
      case (state)
        idle:    if (accept) state <= fetch;
        fetch:   if (mem_rd_req && (req_left == word_cnt_t'(1))) state <= drain;
        drain:   if (last_ret) state <= idle;
        default: state <= idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_adr <= '0;
    end else if (accept) begin
      wr_adr <= '0;            // each load fills from slot 0
    end else if (buf_wr.en) begin
      wr_adr <= wr_adr + 1'b1;
    end
  end

  // returned word goes straight to the bank
  always_comb begin
    buf_wr.en   = mem_rd_valid && (state != idle);
    buf_wr.adr  = wr_adr;
    buf_wr.data = mem_rd_data;
  end

endmodule

//--- logic/weight_ping_pong_buf.sv
`timescale 1ns/1ps

module weight_ping_pong_buf (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 load_start,  // swaps the banks
  input  wl_pkg::buf_wr_s      buf_wr,      // from load controller
  input  wl_pkg::buf_rd_s      buf_rd,      // from vector reader
  output wl_pkg::weight_word_t rd_data      // one cycle after buf_rd.en
);
  import wl_pkg::*;

  logic         fill_sel;      // bank being loaded, other one is read
  logic         rd_sel;        // bank that answered last read
  weight_word_t bank_out [2];  // registered read word per bank

  ////////////////////////////////////////////////////////////////////////////
  // bank select
  ////////////////////////////////////////////////////////////////////////////

  // starts at 1 so the first load_start lands on bank 0
  always_ff @(posedge clk) begin
    if (reset) begin
      fill_sel <= 1'b1;
    end else if (load_start) begin
      fill_sel <= ~fill_sel;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_sel <= 1'b0;
    end else if (buf_rd.en) begin
      rd_sel <= ~fill_sel;  // read bank at request time
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // the two banks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar b = 0; b < 2; b++) begin : g_bank
    weight_word_t mem [BUF_DEPTH];  // inferred block ram
    weight_word_t q;                // output register
    logic         wr_en;
    logic         rd_en;

    assign wr_en = buf_wr.en && (fill_sel == 1'(b));  // fill bank only
    assign rd_en = buf_rd.en && (fill_sel != 1'(b));  // read bank only

    always_ff @(posedge clk) begin
      if (wr_en) begin
        mem[buf_wr.adr] <= buf_wr.data;
      end
      if (rd_en) begin
        q <= mem[buf_rd.adr];
      end
    end

    assign bank_out[b] = q;
  end

  // fill and read sit in different banks, so both run every cycle
  assign rd_data = bank_out[rd_sel];

endmodule

//--- logic/weight_subsystem_top.sv
`timescale 1ns/1ps

module weight_subsystem_top (
  input  logic                 clk,
  input  logic                 reset,
  // load command
  input  logic                 load_start,
  input  wl_pkg::mem_adr_t     load_base,
  input  wl_pkg::word_cnt_t    load_count,
  output logic                 load_done,
  // external memory read port
  output logic                 mem_rd_req,
  output wl_pkg::mem_adr_t     mem_rd_adr,
  input  logic                 mem_rd_valid,
  input  wl_pkg::weight_word_t mem_rd_data,
  // PE side
  input  logic                 fm_en,
  input  logic                 fm_end,
  output logic                 vec_valid,
  output wl_pkg::weight_word_t weight_vec
);
  import wl_pkg::*;

  buf_wr_s      buf_wr;   // controller into fill bank
  buf_rd_s      buf_rd;   // reader into read bank
  weight_word_t rd_data;  // read bank back to reader

  ////////////////////////////////////////////////////////////////////////////
  // producer, buffer, consumer
  ////////////////////////////////////////////////////////////////////////////

  weight_load_ctrl load_ctrl_i (
    .clk          (clk),
    .reset        (reset),
    .load_start   (load_start),
    .load_base    (load_base),
    .load_count   (load_count),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_data  (mem_rd_data),
    .mem_rd_req   (mem_rd_req),
    .mem_rd_adr   (mem_rd_adr),
    .buf_wr       (buf_wr),
    .load_done    (load_done)
  );

  weight_ping_pong_buf ping_pong_i (
    .clk        (clk),
    .reset      (reset),
    .load_start (load_start),  // same pulse flips the banks
    .buf_wr     (buf_wr),
    .buf_rd     (buf_rd),
    .rd_data    (rd_data)
  );

  weight_vector_reader reader_i (
    .clk        (clk),
    .reset      (reset),
    .fm_en      (fm_en),
    .fm_end     (fm_end),
    .rd_data    (rd_data),
    .buf_rd     (buf_rd),
    .vec_valid  (vec_valid),
    .weight_vec (weight_vec)
  );

endmodule

//--- logic/weight_vector_reader.sv
`timescale 1ns/1ps

module weight_vector_reader (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 fm_en,       // PEs want a vector next cycle
  input  logic                 fm_end,      // last word of this pass
  input  wl_pkg::weight_word_t rd_data,     // buffer output, one cycle late
  output wl_pkg::buf_rd_s      buf_rd,
  output logic                 vec_valid,
  output wl_pkg::weight_word_t weight_vec   // to the PE array
);
  import wl_pkg::*;

  buf_adr_t pass_adr;  // word index within the pass

  ////////////////////////////////////////////////////////////////////////////
  // address walk
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pass_adr <= '0;
    end else if (fm_end) begin
      pass_adr <= '0;               // rewind after the last word
    end else if (fm_en) begin
      pass_adr <= pass_adr + 1'b1;  // one word per demand
    end
  end

  // read issued in the demand cycle
  always_comb begin
    buf_rd.en  = fm_en;
    buf_rd.adr = pass_adr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // output alignment
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      vec_valid <= 1'b0;
    end else begin
      vec_valid <= fm_en;  // matches buffer read latency
    end
  end

  // zeros between vectors keep the PE inputs quiet
  assign weight_vec = vec_valid ? rd_data : '0;

endmodule

//--- logic/wl_pkg.sv
package wl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int WORD_W     = 64;  // eight 8-bit weights per word
  localparam int BUF_DEPTH  = 64;  // words per bank
  localparam int BUF_ADR_W  = 6;   // log2 of bank depth
  localparam int MEM_ADR_W  = 16;  // external word address
  localparam int RD_CREDITS = 4;   // max reads in flight
  localparam int CREDIT_W   = 3;   // holds 0..RD_CREDITS

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [WORD_W-1:0]    weight_word_t;  // one memory or bank word
  typedef logic [BUF_ADR_W-1:0] buf_adr_t;      // bank address
  typedef logic [MEM_ADR_W-1:0] mem_adr_t;      // memory word address
  typedef logic [BUF_ADR_W:0]   word_cnt_t;     // load length, 1..64

  ////////////////////////////////////////////////////////////////////////////
  // buffer ports
  ////////////////////////////////////////////////////////////////////////////

  // one word into the fill bank
  typedef struct packed {
    logic         en;
    buf_adr_t     adr;
    weight_word_t data;
  } buf_wr_s;

  // read request to the read bank, data one cycle later
  typedef struct packed {
    logic     en;
    buf_adr_t adr;
  } buf_rd_s;

  // load controller states
  typedef enum logic [1:0] {
    idle,   // waiting for load_start
    fetch,  // requests still to issue
    drain   // all issued, returns pending
  } load_state_e;

endpackage

//--- project.f
logic/wl_pkg.sv
logic/weight_load_ctrl.sv
logic/weight_ping_pong_buf.sv
logic/weight_vector_reader.sv
logic/weight_subsystem_top.sv
tests/weight_mem_model.sv
tests/weight_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module weight_subsystem_tb \
  -o weight_subsystem_sim > build.log 2>&1 \
  && ./obj_dir/weight_subsystem_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2> /dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
exit 0

//--- tests/weight_mem_model.sv
`timescale 1ns/1ps

module weight_mem_model (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 mem_rd_req,
  input  wl_pkg::mem_adr_t     mem_rd_adr,
  output logic                 mem_rd_valid,   // one return per cycle at most
  output wl_pkg::weight_word_t mem_rd_data,
  output int                   credit_errs     // reads beyond the credit pool
);
  import wl_pkg::*;

  integer   seed;          // $random state
  mem_adr_t adr_q [$];     // pending reads, oldest first
  int       due_q [$];     // cycle each pending read comes back
  int       cycle;         // rising edges since start
  int       last_due;      // keeps returns in order
  int       in_flight;     // requested but not yet returned
  int       lat;
  int       due;

  // byte i of word a is a + 17*i, mod 256
  function automatic weight_word_t word_at(input mem_adr_t a);
    weight_word_t w;
    for (int i = 0; i < 8; i++) begin
      w[8*i +: 8] = a[7:0] + 8'(17 * i);
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // return side after the edge, request side mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed         = 32'h4e8b_537e;
    mem_rd_valid = 1'b0;
    mem_rd_data  = '0;
    credit_errs  = 0;
    cycle        = 0;
    last_due     = 0;
    in_flight    = 0;
    forever begin
      @(posedge clk);
      cycle++;
      #2;
      if (!reset && due_q.size() > 0 && due_q[0] == cycle) begin
        mem_rd_valid = 1'b1;
        mem_rd_data  = word_at(adr_q.pop_front());
        due          = due_q.pop_front();  // head served
      end else begin
        mem_rd_valid = 1'b0;
        mem_rd_data  = '0;
      end
      @(negedge clk);
      if (reset) begin
        adr_q.delete();
        due_q.delete();
        in_flight = 0;
      end else begin
        if (mem_rd_req) begin
          lat = 1 + ($random(seed) & 3);  // 1 to 4 cycles
          due = cycle + lat;
          if (due <= last_due) due = last_due + 1;  // never overtake
          last_due = due;
          adr_q.push_back(mem_rd_adr);
          due_q.push_back(due);
        end
        if (in_flight + (mem_rd_req ? 1 : 0) > RD_CREDITS) begin
          $display("memory model: more than %0d reads outstanding at cycle %0d",
                   RD_CREDITS, cycle);
          credit_errs++;
        end
        in_flight = in_flight + (mem_rd_req ? 1 : 0) - (mem_rd_valid ? 1 : 0);
      end
    end
  end

endmodule

//--- tests/weight_subsystem_tb.sv
`timescale 1ns/1ps

module weight_subsystem_tb;
  import wl_pkg::*;

  localparam int N_ROWS       = 5;
  localparam int LOAD_TIMEOUT = 1000;  // cycles allowed per load

  // one load and the pass that later reads it back
  typedef struct packed {
    mem_adr_t     base;
    word_cnt_t    count;
    word_cnt_t    pass_len;
    weight_word_t first_vec;  // word at base, worked out by hand
  } row_s;

  logic         clk;
  logic         reset;
  logic         load_start;
  mem_adr_t     load_base;
  word_cnt_t    load_count;
  logic         load_done;
  logic         mem_rd_req;
  mem_adr_t     mem_rd_adr;
  logic         mem_rd_valid;
  weight_word_t mem_rd_data;
  logic         fm_en;
  logic         fm_end;
  logic         vec_valid;
  weight_word_t weight_vec;
  int           credit_errs;  // from memory model
  int           value_errs;   // wrong values
  int           other_errs;   // timeouts and extra pulses
  row_s         rows [N_ROWS];

  weight_subsystem_top dut_i (
    .clk          (clk),
    .reset        (reset),
    .load_start   (load_start),
    .load_base    (load_base),
    .load_count   (load_count),
    .load_done    (load_done),
    .mem_rd_req   (mem_rd_req),
    .mem_rd_adr   (mem_rd_adr),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_data  (mem_rd_data),
    .fm_en        (fm_en),
    .fm_end       (fm_end),
    .vec_valid    (vec_valid),
    .weight_vec   (weight_vec)
  );

  weight_mem_model mem_i (
    .clk          (clk),
    .reset        (reset),
    .mem_rd_req   (mem_rd_req),
    .mem_rd_adr   (mem_rd_adr),
    .mem_rd_valid (mem_rd_valid),
    .mem_rd_data  (mem_rd_data),
    .credit_errs  (credit_errs)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;  // 20 ns period
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks and expected data
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_vec(input string name, input weight_word_t exp, input weight_word_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_adr(input string name, input mem_adr_t exp, input mem_adr_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_count(input string name, input word_cnt_t exp, input word_cnt_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_level(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
      value_errs++;
    end
  endtask

  // byte i of word a is a + 17*i, mod 256
  function automatic weight_word_t rule_word(input mem_adr_t a);
    weight_word_t w;
    for (int i = 0; i < 8; i++) begin
      w[8*i +: 8] = a[7:0] + 8'(17 * i);
    end
    return w;
  endfunction

  function automatic row_s make_row(input mem_adr_t base, input word_cnt_t count,
                                    input word_cnt_t pass_len, input weight_word_t first_vec);
    row_s r;
    r.base      = base;
    r.count     = count;
    r.pass_len  = pass_len;
    r.first_vec = first_vec;
    return r;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // load and pass sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic start_load(input row_s row);
    @(posedge clk);
    #2;
    load_start = 1'b1;  // also flips the banks
    load_base  = row.base;
    load_count = row.count;
    @(posedge clk);
    #2;
    load_start = 1'b0;
  endtask

  task automatic watch_load(input row_s row, input string name);
    mem_adr_t exp_adr;
    int       reqs;
    int       dones;
    int       cycles;
    exp_adr = row.base;
    reqs    = 0;
    dones   = 0;
    cycles  = 0;
    while (dones == 0 && cycles < LOAD_TIMEOUT) begin
      @(negedge clk);  // mid-cycle sample
      cycles++;
      if (mem_rd_req) begin
        check_adr($sformatf("%s request %0d", name, reqs), exp_adr, mem_rd_adr);
        exp_adr++;
        reqs++;
      end
      if (load_done) dones++;
    end
    if (dones == 0) begin
      $display("%s: load_done did not come within %0d cycles", name, LOAD_TIMEOUT);
      other_errs++;
    end
    check_count($sformatf("%s request total", name), row.count, word_cnt_t'(reqs));
    @(negedge clk);
    if (load_done) begin
      $display("%s: load_done stayed high for more than one cycle", name);
      other_errs++;
    end
    check_level($sformatf("%s request after done", name), 1'b0, mem_rd_req);
  endtask

  task automatic run_pass(input row_s row, input string name);
    weight_word_t exp;
    int           len;
    len = int'(row.pass_len);
    for (int k = 0; k <= len + 1; k++) begin
      @(posedge clk);
      #2;
      fm_en  = (k < len);
      fm_end = (k == len - 1);  // last word rewinds the reader
      @(negedge clk);
      check_level($sformatf("%s valid %0d", name, k), (k >= 1 && k <= len), vec_valid);
      if (k >= 1 && k <= len) begin
        if (k == 1) exp = row.first_vec;
        else exp = rule_word(row.base + mem_adr_t'(k - 1));
        check_vec($sformatf("%s vec %0d", name, k - 1), exp, weight_vec);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    reset      = 1'b1;
    load_start = 1'b0;
    load_base  = '0;
    load_count = '0;
    fm_en      = 1'b0;
    fm_end     = 1'b0;
    value_errs = 0;
    other_errs = 0;
    rows[0] = make_row(16'h0100, 7'd8,  7'd8,  64'h7766_5544_3322_1100);
    rows[1] = make_row(16'h0340, 7'd64, 7'd64, 64'hb7a6_9584_7362_5140);  // full bank
    rows[2] = make_row(16'h00ff, 7'd1,  7'd1,  64'h7665_5443_3221_10ff);  // single word
    rows[3] = make_row(16'hfff0, 7'd20, 7'd12, 64'h6756_4534_2312_01f0);  // address wraps
    rows[4] = make_row(16'h1234, 7'd33, 7'd33, 64'hab9a_8978_6756_4534);
    for (int i = 0; i < 17; i++) begin
      @(negedge clk);
      check_level("request in reset", 1'b0, mem_rd_req);
      check_level("load_done in reset", 1'b0, load_done);
      check_level("vec_valid in reset", 1'b0, vec_valid);
      if (i == 14) begin
        @(posedge clk);
        #2;
        reset = 1'b0;  // two more checks follow
      end
    end
    start_load(rows[0]);  // first load, nothing to read yet
    watch_load(rows[0], "row 0 first load");
    for (int r = 1; r <= N_ROWS; r++) begin
      start_load(rows[r % N_ROWS]);
      fork
        watch_load(rows[r % N_ROWS], $sformatf("row %0d load", r % N_ROWS));
        begin
          run_pass(rows[r - 1], $sformatf("row %0d pass 1", r - 1));
          run_pass(rows[r - 1], $sformatf("row %0d pass 2", r - 1));  // same bank again
        end
      join
    end
    $display("value errors: %0d, other errors: %0d, memory credit errors: %0d",
             value_errs, other_errs, credit_errs);
    if (value_errs + other_errs + credit_errs == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule
